// File: build.f
src/raster_pkg.sv
src/jitter_cfg_pkg.sv
src/tree_hash.sv
src/jitter_cfg_regs.sv
src/pipe_delay.sv
src/hash_jtree.sv
src/jitter_top.sv
verification/jitter_assert.sv
verification/tb_jitter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the jitter stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_jitter -o vsim

out=$(./obj_dir/vsim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: src/hash_jtree.sv
/*
 * Sample jitter stage
 *   Two XOR-tree hashes per sample give an X and a Y offset
 *   from the high-order position bits. The offsets are ORed into
 *   the subpixel bits, then triangle, color and jittered samples
 *   travel through a PIPE_DEPTH delay line with their valid bits.
 */
`timescale 1ns/1ps

module hash_jtree #(
    parameter int PIPE_DEPTH = 3,
    parameter int MULTI_SAMP = 2
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  jitter_cfg_pkg::hash_mask_t           hash_mask,       // Current mode mask
    input  raster_pkg::triangle_t                tri_in,
    input  raster_pkg::tri_color_t               color_in,
    input  raster_pkg::sample_t [MULTI_SAMP-1:0] sample_in,       // Sample centers
    input  logic [MULTI_SAMP-1:0]                sample_valid_in, // One bit per sample
    output raster_pkg::triangle_t                tri_out,
    output raster_pkg::tri_color_t               color_out,
    output raster_pkg::sample_t [MULTI_SAMP-1:0] sample_out,      // Jittered positions
    output logic [MULTI_SAMP-1:0]                sample_valid_out
);

    localparam int SIGFIG   = raster_pkg::SIGFIG;
    localparam int RADIX    = raster_pkg::RADIX;
    localparam int HASH_W   = jitter_cfg_pkg::HASH_WIDTH;
    localparam int HASH_IN  = jitter_cfg_pkg::HASH_IN_WIDTH;
    localparam int LOW_PAD  = RADIX - HASH_W;   // Bits below the offset, 2
    localparam int HIGH_PAD = SIGFIG - RADIX;   // Integer part, 14

    // One word through the delay line
    typedef struct packed {
        raster_pkg::tri_bundle_t              head;
        raster_pkg::sample_t [MULTI_SAMP-1:0] samples;
    } stage_word_t;

    localparam int WORD_W = $bits(stage_word_t);

    raster_pkg::sample_t [MULTI_SAMP-1:0] jit_samples;   // After jitter, before pipe
    stage_word_t                          stage_in;
    stage_word_t                          stage_out;

    for (genvar s = 0; s < MULTI_SAMP; s++) begin : g_samp
        logic [HASH_IN-1:0]         x_key;      // y high bits over x high bits
        logic [HASH_IN-1:0]         y_key;      // Swapped halves
        jitter_cfg_pkg::hash_mask_t x_jit;
        jitter_cfg_pkg::hash_mask_t y_jit;

        assign x_key = {sample_in[s].y[SIGFIG-1:4], sample_in[s].x[SIGFIG-1:4]};
        assign y_key = {sample_in[s].x[SIGFIG-1:4], sample_in[s].y[SIGFIG-1:4]};

        tree_hash #(
            .IN_WIDTH  (HASH_IN),
            .OUT_WIDTH (HASH_W)
        ) u_xjit_hash (
            .hash_in  (x_key),
            .mask     (hash_mask),
            .hash_out (x_jit)
        );

        tree_hash #(
            .IN_WIDTH  (HASH_IN),
            .OUT_WIDTH (HASH_W)
        ) u_yjit_hash (
            .hash_in  (y_key),
            .mask     (hash_mask),
            .hash_out (y_jit)
        );

        // Offset lands in bits 9:2, integer part untouched
        assign jit_samples[s].x = sample_in[s].x
                                | {{HIGH_PAD{1'b0}}, x_jit, {LOW_PAD{1'b0}}};
        assign jit_samples[s].y = sample_in[s].y
                                | {{HIGH_PAD{1'b0}}, y_jit, {LOW_PAD{1'b0}}};
    end

    assign stage_in.head.geom  = tri_in;        // Triangle passes unchanged
    assign stage_in.head.color = color_in;
    assign stage_in.samples    = jit_samples;

    pipe_delay #(
        .WIDTH       (WORD_W),
        .VALID_WIDTH (MULTI_SAMP),
        .DEPTH       (PIPE_DEPTH)
    ) u_delay (
        .clk       (clk),
        .reset     (reset),
        .data_in   (stage_in),
        .valid_in  (sample_valid_in),
        .data_out  (stage_out),
        .valid_out (sample_valid_out)
    );

    assign tri_out    = stage_out.head.geom;
    assign color_out  = stage_out.head.color;
    assign sample_out = stage_out.samples;

endmodule

// File: src/jitter_cfg_pkg.sv
/*
 * Jitter configuration types
 *   HASH_WIDTH, HASH_IN_WIDTH   hash output and input widths
 *   subsample_t, hash_mask_t    mode register and hash mask
 *   SUBSAMP_* and MASK_*        one-hot modes and their masks
 */
package jitter_cfg_pkg;

    localparam int HASH_WIDTH    = raster_pkg::RADIX - 2;          // Jitter offset bits
    localparam int HASH_IN_WIDTH = (raster_pkg::SIGFIG - 4) * 2;   // Two truncated coords

    typedef logic [3:0]            subsample_t;   // One-hot samples per pixel
    typedef logic [HASH_WIDTH-1:0] hash_mask_t;   // Mask on hash output

    localparam subsample_t SUBSAMP_1X  = 4'b1000; // 1 sample per pixel
    localparam subsample_t SUBSAMP_4X  = 4'b0100;
    localparam subsample_t SUBSAMP_16X = 4'b0010;
    localparam subsample_t SUBSAMP_64X = 4'b0001;

    localparam hash_mask_t MASK_1X  = 8'hFF;      // Full subpixel range
    localparam hash_mask_t MASK_4X  = 8'h7F;
    localparam hash_mask_t MASK_16X = 8'h3F;
    localparam hash_mask_t MASK_64X = 8'h1F;      // Finest grid, smallest offset

endpackage

// File: src/jitter_cfg_regs.sv
/*
 * Subsample configuration registers
 *   Mode register, written only with one-hot values
 *   Sticky error flag for rejected writes
 *   Decode of the stored mode into the hash mask
 */
`timescale 1ns/1ps

module jitter_cfg_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cfg_write,     // One-cycle write strobe
    input  jitter_cfg_pkg::subsample_t cfg_subsample, // Requested mode
    output jitter_cfg_pkg::hash_mask_t hash_mask,     // Mask for the jitter hash
    output logic                       cfg_error      // Illegal write seen
);

    jitter_cfg_pkg::subsample_t mode_q;         // Current mode, always one-hot
    logic                       error_q;        // Sticky until reset
    logic                       write_legal;    // Exactly one bit set

    assign write_legal = $onehot(cfg_subsample);

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q  <= jitter_cfg_pkg::SUBSAMP_1X;  // 1 spp after reset
            error_q <= 1'b0;
        end else if (cfg_write) begin
            if (write_legal) begin
                mode_q <= cfg_subsample;            // Takes effect next cycle
            end else begin
                error_q <= 1'b1;                    // Keep old mode
            end
        end
    end

    // Coarser sampling allows a wider offset
    always_comb begin
        unique case (1'b1)
            mode_q[3]: hash_mask = jitter_cfg_pkg::MASK_1X;
            mode_q[2]: hash_mask = jitter_cfg_pkg::MASK_4X;
            mode_q[1]: hash_mask = jitter_cfg_pkg::MASK_16X;
            mode_q[0]: hash_mask = jitter_cfg_pkg::MASK_64X;
            default:   hash_mask = jitter_cfg_pkg::MASK_1X;
        endcase
    end

    assign cfg_error = error_q;

endmodule

// File: src/jitter_top.sv
/*
 * Jitter stage top level
 *   Configuration registers feeding the hash mask
 *   Sample jitter stage with its fixed-latency pipe
 */
`timescale 1ns/1ps

module jitter_top #(
    parameter int PIPE_DEPTH = 3,               // Stage latency in cycles
    parameter int MULTI_SAMP = 2                // Samples per cycle
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 cfg_write,
    input  jitter_cfg_pkg::subsample_t           cfg_subsample,
    output logic                                 cfg_error,
    input  raster_pkg::triangle_t                tri_in,
    input  raster_pkg::tri_color_t               color_in,
    input  raster_pkg::sample_t [MULTI_SAMP-1:0] sample_in,
    input  logic [MULTI_SAMP-1:0]                sample_valid_in,
    output raster_pkg::triangle_t                tri_out,
    output raster_pkg::tri_color_t               color_out,
    output raster_pkg::sample_t [MULTI_SAMP-1:0] sample_out,
    output logic [MULTI_SAMP-1:0]                sample_valid_out
);

    jitter_cfg_pkg::hash_mask_t hash_mask;      // Mode decode to jitter stage

    jitter_cfg_regs u_cfg (
        .clk           (clk),
        .reset         (reset),
        .cfg_write     (cfg_write),
        .cfg_subsample (cfg_subsample),
        .hash_mask     (hash_mask),
        .cfg_error     (cfg_error)
    );

    hash_jtree #(
        .PIPE_DEPTH (PIPE_DEPTH),
        .MULTI_SAMP (MULTI_SAMP)
    ) u_jtree (
        .clk              (clk),
        .reset            (reset),
        .hash_mask        (hash_mask),
        .tri_in           (tri_in),
        .color_in         (color_in),
        .sample_in        (sample_in),
        .sample_valid_in  (sample_valid_in),
        .tri_out          (tri_out),
        .color_out        (color_out),
        .sample_out       (sample_out),
        .sample_valid_out (sample_valid_out)
    );

endmodule

// File: src/pipe_delay.sv
/*
 * Fixed-latency delay line
 *   DEPTH register stages for a data word and its valid bits.
 *   Valid stages clear on reset, data stages keep their contents.
 */
`timescale 1ns/1ps

module pipe_delay #(
    parameter int WIDTH       = 8,
    parameter int VALID_WIDTH = 1,
    parameter int DEPTH       = 1              // At least one stage
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [WIDTH-1:0]       data_in,
    input  logic [VALID_WIDTH-1:0] valid_in,
    output logic [WIDTH-1:0]       data_out,   // data_in from DEPTH cycles ago
    output logic [VALID_WIDTH-1:0] valid_out
);

    logic [WIDTH-1:0]       data_q [DEPTH];     // Payload chain
    logic [VALID_WIDTH-1:0] valid_q [DEPTH];    // Valid chain

    always_ff @(posedge clk) begin
        data_q[0] <= data_in;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];           // Shift one stage
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= '0;               // Flush all stages
            end
        end else begin
            valid_q[0] <= valid_in;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign data_out  = data_q[DEPTH-1];
    assign valid_out = valid_q[DEPTH-1];

endmodule

// File: src/raster_pkg.sv
/*
 * Geometry types for the raster pipeline
 *   SIGFIG, RADIX        fixed-point widths
 *   coord_t, color_t     scalar coordinate and color channel
 *   vertex_t, triangle_t triangle geometry
 *   tri_color_t          flat triangle color
 *   sample_t             sample position
 *   tri_bundle_t         triangle plus color as carried down the pipe
 */
package raster_pkg;

    localparam int SIGFIG = 24;                 // Coordinate and color width
    localparam int RADIX  = 10;                 // Fraction bits of a coordinate

    typedef logic signed [SIGFIG-1:0] coord_t;  // Signed fixed point
    typedef logic        [SIGFIG-1:0] color_t;  // Unsigned channel

    typedef struct packed {
        coord_t x;                              // Screen x
        coord_t y;                              // Screen y
        coord_t z;                              // Depth
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } tri_color_t;

    typedef struct packed {
        coord_t x;                              // Sample x, pixel + subpixel
        coord_t y;                              // Sample y
    } sample_t;

    // Per-triangle part of a pipe word, samples are appended per instance
    typedef struct packed {
        triangle_t  geom;
        tri_color_t color;
    } tri_bundle_t;

endpackage

// File: src/tree_hash.sv
/*
 * XOR folding hash
 *   Splits the input into OUT_WIDTH slices, last one zero padded,
 *   XORs all slices together and masks the result.
 *   Purely combinational.
 */
`timescale 1ns/1ps

module tree_hash #(
    parameter int IN_WIDTH  = jitter_cfg_pkg::HASH_IN_WIDTH,
    parameter int OUT_WIDTH = jitter_cfg_pkg::HASH_WIDTH
) (
    input  logic [IN_WIDTH-1:0]       hash_in,  // Folded coordinate bits
    input  jitter_cfg_pkg::hash_mask_t mask,    // From subsample mode
    output jitter_cfg_pkg::hash_mask_t hash_out // Masked offset
);

    localparam int NUM_SLICES = (IN_WIDTH + OUT_WIDTH - 1) / OUT_WIDTH; // Round up
    localparam int PAD_WIDTH  = NUM_SLICES * OUT_WIDTH;

    logic [PAD_WIDTH-1:0] padded;               // Input widened to whole slices
    logic [OUT_WIDTH-1:0] folded;               // XOR of all slices

    assign padded = PAD_WIDTH'(hash_in);        // Zero fill on top

    // Bit i collects input bits i, i+OUT_WIDTH, i+2*OUT_WIDTH ...
    always_comb begin
        folded = '0;
        for (int i = 0; i < NUM_SLICES; i++) begin
            folded = folded ^ padded[i*OUT_WIDTH +: OUT_WIDTH];
        end
    end

    assign hash_out = folded & mask;            // Clip to subsample grid

endmodule

// File: verification/jitter_assert.sv
/*
 * Concurrent assertions for jitter_top
 *   Valid outputs known after reset
 *   Valid bits delayed by exactly PIPE_DEPTH cycles
 *   Sticky configuration error
 */
`timescale 1ns/1ps

module jitter_assert #(
    parameter int PIPE_DEPTH = 3,
    parameter int MULTI_SAMP = 2
) (
    input logic                  clk,
    input logic                  reset,
    input logic [MULTI_SAMP-1:0] sample_valid_in,
    input logic [MULTI_SAMP-1:0] sample_valid_out,
    input logic                  cfg_error
);

    int since_reset;                            // Edges seen with reset low, saturating

    always_ff @(posedge clk) begin
        if (reset) begin
            since_reset <= 0;
        end else if (since_reset < PIPE_DEPTH) begin
            since_reset <= since_reset + 1;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(sample_valid_out))
        else $error("sample_valid_out unknown");

    // Pipe filled with post-reset inputs
    a_valid_delay: assert property (@(posedge clk) disable iff (reset)
        (since_reset >= PIPE_DEPTH) |-> sample_valid_out == $past(sample_valid_in, PIPE_DEPTH))
        else $error("sample_valid_out does not follow sample_valid_in");

    a_error_sticky: assert property (@(posedge clk) disable iff (reset)
        $fell(cfg_error) |-> $past(reset))
        else $error("cfg_error cleared without reset");

endmodule

bind jitter_top jitter_assert #(
    .PIPE_DEPTH (PIPE_DEPTH),
    .MULTI_SAMP (MULTI_SAMP)
) u_assert (
    .clk              (clk),
    .reset            (reset),
    .sample_valid_in  (sample_valid_in),
    .sample_valid_out (sample_valid_out),
    .cfg_error        (cfg_error)
);

// File: verification/tb_jitter.sv
/*
 * Testbench for jitter_top
 *   Clock, reset and xorshift stimulus on the falling edge
 *   Reference model of hash, mask and mode register with an expect queue
 *   Typed compare tasks, per-test report and watchdog
 */
`timescale 1ns/1ps

module tb_jitter;

    localparam int PIPE_DEPTH     = 3;
    localparam int MULTI_SAMP     = 2;
    localparam int CLK_PERIOD     = 4;          // ns
    localparam int RESET_CYCLES   = 5;
    localparam int DEFAULT_CYCLES = 40;
    localparam int MODE_CYCLES    = 12;         // After each write
    localparam int VALID_CYCLES   = 40;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + PIPE_DEPTH + DEFAULT_CYCLES
                                  + 7 * (1 + MODE_CYCLES) + VALID_CYCLES + PIPE_DEPTH;
    localparam int MARGIN_CYCLES  = 50;

    typedef struct packed {
        raster_pkg::triangle_t                geom;
        raster_pkg::tri_color_t               color;
        raster_pkg::sample_t [MULTI_SAMP-1:0] samples;
        logic [MULTI_SAMP-1:0]                valid;
    } expect_t;

    logic                                 clk;
    logic                                 reset;
    logic                                 cfg_write;
    jitter_cfg_pkg::subsample_t           cfg_subsample;
    logic                                 cfg_error;
    raster_pkg::triangle_t                tri_in, tri_out;
    raster_pkg::tri_color_t               color_in, color_out;
    raster_pkg::sample_t [MULTI_SAMP-1:0] sample_in, sample_out;
    logic [MULTI_SAMP-1:0]                sample_valid_in, sample_valid_out;

    expect_t                    exp_q[$];       // Entries still inside the pipe
    jitter_cfg_pkg::subsample_t m_mode;         // Model mode register
    logic                       m_err;          // Model sticky error
    logic [31:0]                rng_state;
    string                      cur_test;
    int errors, checks, tests, test_err_start;

    jitter_top #(
        .PIPE_DEPTH (PIPE_DEPTH),
        .MULTI_SAMP (MULTI_SAMP)
    ) dut0 (
        .clk              (clk),
        .reset            (reset),
        .cfg_write        (cfg_write),
        .cfg_subsample    (cfg_subsample),
        .cfg_error        (cfg_error),
        .tri_in           (tri_in),
        .color_in         (color_in),
        .sample_in        (sample_in),
        .sample_valid_in  (sample_valid_in),
        .tri_out          (tri_out),
        .color_out        (color_out),
        .sample_out       (sample_out),
        .sample_valid_out (sample_valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Bit i is the XOR of key bits i, i+8, i+16, i+24, i+32
    function automatic jitter_cfg_pkg::hash_mask_t model_hash(
        input logic [39:0]                key,
        input jitter_cfg_pkg::hash_mask_t mask
    );
        jitter_cfg_pkg::hash_mask_t h;
        for (int i = 0; i < 8; i++) begin
            h[i] = 1'b0;
            for (int k = 0; k < 5; k++) begin
                h[i] = h[i] ^ key[i + 8 * k];
            end
        end
        return h & mask;
    endfunction

    function automatic jitter_cfg_pkg::hash_mask_t mode_mask(
        input jitter_cfg_pkg::subsample_t mode
    );
        case (mode)
            4'b1000: return 8'hFF;
            4'b0100: return 8'h7F;
            4'b0010: return 8'h3F;
            4'b0001: return 8'h1F;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic is_one_hot(input jitter_cfg_pkg::subsample_t mode);
        int ones;
        ones = 0;
        for (int i = 0; i < 4; i++) begin
            ones = ones + int'(mode[i]);
        end
        return ones == 1;
    endfunction

    function automatic raster_pkg::coord_t jitter_coord(input raster_pkg::coord_t c,
                                                        input jitter_cfg_pkg::hash_mask_t h);
        return c | {14'b0, h, 2'b0};            // Offset into bits 9:2
    endfunction

    task automatic sample_compare(input string what, input raster_pkg::sample_t exp,
                                  input raster_pkg::sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic tri_compare(input raster_pkg::triangle_t exp,
                               input raster_pkg::triangle_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s tri_out: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic color_compare(input raster_pkg::tri_color_t exp,
                                 input raster_pkg::tri_color_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s color_out: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic valid_compare(input logic [MULTI_SAMP-1:0] exp,
                                 input logic [MULTI_SAMP-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s sample_valid_out: expected %b actual %b", cur_test, exp, act);
        end
    endtask

    task automatic flag_compare(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s cfg_error: expected %b actual %b", cur_test, exp, act);
        end
    endtask

    // Entry driven PIPE_DEPTH falling edges ago is on the outputs now
    task automatic score_outputs();
        expect_t e;
        flag_compare(m_err, cfg_error);
        if (exp_q.size() >= PIPE_DEPTH) begin
            e = exp_q.pop_front();
            valid_compare(e.valid, sample_valid_out);
            if (|e.valid) begin
                tri_compare(e.geom, tri_out);
                color_compare(e.color, color_out);
                for (int s = 0; s < MULTI_SAMP; s++) begin
                    sample_compare($sformatf("sample%0d", s), e.samples[s], sample_out[s]);
                end
            end
        end else begin
            valid_compare('0, sample_valid_out);    // Pipe still in reset state
        end
    endtask

    // vsel selects no valid bits (0), all of them (1) or a random pattern (2)
    task automatic run_cycle(input logic rst, input logic wr,
                             input jitter_cfg_pkg::subsample_t mode, input int vsel);
        expect_t                    e;
        logic [287:0]               wide;
        logic [63:0]                word;
        logic [31:0]                r;
        jitter_cfg_pkg::hash_mask_t mask;
        @(negedge clk);
        score_outputs();
        for (int k = 0; k < 9; k++) begin
            wide[32 * k +: 32] = next_rand();
        end
        tri_in   = wide[215:0];
        color_in = wide[287:216];
        for (int s = 0; s < MULTI_SAMP; s++) begin
            word = {next_rand(), next_rand()};
            sample_in[s] = word[47:0];
        end
        r = next_rand();
        sample_valid_in = (vsel == 0) ? '0 : (vsel == 1) ? '1 : r[MULTI_SAMP-1:0];
        reset         = rst;
        cfg_write     = wr;
        cfg_subsample = mode;
        if (rst) begin
            for (int i = 0; i < exp_q.size(); i++) begin
                e = exp_q[i];
                e.valid = '0;                   // Pipe flushed by reset
                exp_q[i] = e;
            end
            m_mode = 4'b1000;
            m_err  = 1'b0;
        end
        mask    = mode_mask(m_mode);            // Mode in force at the sampling edge
        e.geom  = tri_in;
        e.color = color_in;
        e.valid = rst ? '0 : sample_valid_in;
        for (int s = 0; s < MULTI_SAMP; s++) begin
            e.samples[s].x = jitter_coord(sample_in[s].x,
                model_hash({sample_in[s].y[23:4], sample_in[s].x[23:4]}, mask));
            e.samples[s].y = jitter_coord(sample_in[s].y,
                model_hash({sample_in[s].x[23:4], sample_in[s].y[23:4]}, mask));
        end
        exp_q.push_back(e);
        if (!rst && wr) begin
            if (is_one_hot(mode)) m_mode = mode;
            else m_err = 1'b1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%s done, %0d errors", cur_test, errors - test_err_start);
    endtask

    // Write one mode and run random traffic under it
    task automatic write_then_run(input jitter_cfg_pkg::subsample_t mode);
        run_cycle(1'b0, 1'b1, mode, 2);
        repeat (MODE_CYCLES) run_cycle(1'b0, 1'b0, 4'b0000, 2);
    endtask

    initial begin
        #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN_CYCLES));
        $display("watchdog timeout, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        rng_state       = 32'd18187;
        reset           = 1'b1;
        cfg_write       = 1'b0;
        cfg_subsample   = 4'b1000;
        tri_in          = '0;
        color_in        = '0;
        sample_in       = '0;
        sample_valid_in = '0;
        m_mode          = 4'b1000;
        m_err           = 1'b0;
        errors          = 0;
        checks          = 0;
        tests           = 0;

        start_test("reset");                    // Random valid must not leak through
        repeat (RESET_CYCLES) run_cycle(1'b1, 1'b0, 4'b0000, 2);
        repeat (PIPE_DEPTH) run_cycle(1'b0, 1'b0, 4'b0000, 2);
        end_test();

        start_test("default_mode");
        repeat (DEFAULT_CYCLES) run_cycle(1'b0, 1'b0, 4'b0000, 1);
        end_test();

        start_test("mode_sweep");
        write_then_run(4'b1000);
        write_then_run(4'b0100);
        write_then_run(4'b0010);
        write_then_run(4'b0001);
        end_test();

        start_test("illegal_write");            // Mode stays at 64x until the legal write
        write_then_run(4'b0000);
        write_then_run(4'b0110);
        write_then_run(4'b0100);
        end_test();

        start_test("valid_patterns");
        repeat (VALID_CYCLES) run_cycle(1'b0, 1'b0, 4'b0000, 2);
        repeat (PIPE_DEPTH) run_cycle(1'b0, 1'b0, 4'b0000, 0);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
